//--- verilog/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// set index bits, 16 sets
`define DCACHE_INDEX_W 4

// byte offset inside the single word of a line
`define DCACHE_OFFSET_W 2

// associativity
`define DCACHE_WAYS 2

// tag is whatever is left of the 32-bit address
`define DCACHE_TAG_W (32 - `DCACHE_INDEX_W - `DCACHE_OFFSET_W)

`endif

//--- verilog/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

    // normal access view, tag / set / byte
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]    tag;
        logic [`DCACHE_INDEX_W-1:0]  index;
        logic [`DCACHE_OFFSET_W-1:0] offset;
    } dcache_cache_addr_t;

    // index-type cache op view
    // way select sits in bit 0, set index in the usual place
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]    unused_tag;
        logic [`DCACHE_INDEX_W-1:0]  index;
        logic [`DCACHE_OFFSET_W-2:0] unused_offset;
        logic                        way;
    } dcache_op_addr_t;

    // one request word, read either way depending on req_op
    typedef union packed {
        dcache_cache_addr_t cache;
        dcache_op_addr_t    op;
    } dcache_addr_u;

    // cache ops from the pipeline
    typedef enum logic [1:0] {
        op_index_init  = 2'd0,
        op_index_inval = 2'd1,
        op_hit_inval   = 2'd2
    } cacheop_e;

endpackage

//--- verilog/dcache_req_buf.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_req_buf import dcache_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         load,
    input  logic         req_op,
    input  logic         req_write,
    input  logic         req_uncached,
    input  cacheop_e     req_cacheop,
    input  dcache_addr_u req_addr,
    input  logic [31:0]  req_wdata,
    input  logic [3:0]   req_wstrb,
    output logic         buf_op,
    output logic         buf_write,
    output logic         buf_uncached,
    output cacheop_e     buf_cacheop,
    output dcache_addr_u buf_addr,
    output logic [31:0]  buf_wdata,
    output logic [3:0]   buf_wstrb
);

    //////////////////////////////////////////////////////////////////////
    // request capture
    //////////////////////////////////////////////////////////////////////

    // load follows req_ready, so a held request is taken exactly once
    // contents stay put through lookup and the memory wait states
    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_op       <= 1'b0;
            buf_write    <= 1'b0;
            buf_uncached <= 1'b0;
            buf_cacheop  <= op_index_init;
            buf_addr     <= '0;
            buf_wdata    <= '0;
            buf_wstrb    <= '0;
        end else if (load) begin
            buf_op       <= req_op;
            buf_write    <= req_write;
            buf_uncached <= req_uncached;
            buf_cacheop  <= req_cacheop;
            buf_addr     <= req_addr;
            buf_wdata    <= req_wdata;
            buf_wstrb    <= req_wstrb;
        end
    end

endmodule

//--- verilog/dcache_lru.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_lru (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [`DCACHE_INDEX_W-1:0] index,
    input  logic                       use0,
    input  logic                       use1,
    output logic                       victim
);

    localparam int sets = 1 << `DCACHE_INDEX_W;

    // one bit per set, names the way to throw out next
    logic [sets-1:0] lru_bits;

    assign victim = lru_bits[index];

    // touching a way points the set at the other one
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_bits <= '0;
        end else if (use0) begin
            lru_bits[index] <= 1'b1;
        end else if (use1) begin
            lru_bits[index] <= 1'b0;
        end
    end

    // fsm only ever touches one way per cycle
    a_use_onehot: assert property (@(posedge clk) disable iff (!rstn)
        !(use0 && use1));

endmodule

//--- verilog/dcache_way.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_way import dcache_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  dcache_addr_u addr,
    input  logic [31:0]  wdata,
    input  logic [31:0]  fill_data,
    input  logic [3:0]   wstrb,
    input  logic         data_we,
    input  logic         fill,
    input  logic         inval,
    input  logic         init,
    output logic         hit,
    output logic [31:0]  rdata
);

    localparam int sets = 1 << `DCACHE_INDEX_W;

    logic [`DCACHE_TAG_W-1:0]    tag_mem [sets];
    logic [31:0]                 data_mem [sets];
    logic [sets-1:0]             valid_bits;
    logic [`DCACHE_INDEX_W-1:0]  idx;

    // index ops use the same set bits, so one view is enough here
    assign idx   = addr.cache.index;
    assign rdata = data_mem[idx];
    assign hit   = valid_bits[idx] && (tag_mem[idx] == addr.cache.tag);

    //////////////////////////////////////////////////////////////////////
    // tag and valid
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_bits <= '0;
        end else if (init || inval) begin
            valid_bits[idx] <= 1'b0;
        end else if (data_we && fill) begin
            valid_bits[idx] <= 1'b1;
        end
    end

    // init also zeroes the tag, plain invalidate leaves it
    always_ff @(posedge clk) begin
        if (init) begin
            tag_mem[idx] <= '0;
        end else if (data_we && fill) begin
            tag_mem[idx] <= addr.cache.tag;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // data
    //////////////////////////////////////////////////////////////////////

    // refill writes the whole word, store hit merges under the strobes
    always_ff @(posedge clk) begin
        if (data_we) begin
            if (fill) begin
                data_mem[idx] <= fill_data;
            end else begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) begin
                        data_mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    a_we_vs_inval: assert property (@(posedge clk) disable iff (!rstn)
        !(data_we && inval));

endmodule

//--- verilog/dcache_fsm.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_fsm import dcache_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    // pipeline
    input  logic                    req_valid,
    input  logic                    req_op,
    output logic                    req_ready,
    output logic                    resp_valid,
    output logic                    op_ack,
    // request buffer
    output logic                    buf_load,
    input  logic                    buf_write,
    input  logic                    buf_uncached,
    input  cacheop_e                buf_cacheop,
    input  dcache_addr_u            buf_addr,
    // ways and lru
    input  logic [`DCACHE_WAYS-1:0] hit,
    input  logic                    victim,
    output logic [`DCACHE_WAYS-1:0] data_we,
    output logic [`DCACHE_WAYS-1:0] fill,
    output logic [`DCACHE_WAYS-1:0] inval,
    output logic [`DCACHE_WAYS-1:0] init,
    output logic                    use0,
    output logic                    use1,
    // memory
    input  logic                    mem_addr_ok,
    input  logic                    mem_data_ok,
    output logic                    mem_req,
    output logic                    mem_wr,
    // read data mux
    output logic                    way_sel,
    output logic                    return_sel
);

    localparam logic [2:0] st_idle        = 3'd0;
    localparam logic [2:0] st_lookup      = 3'd1;
    localparam logic [2:0] st_operation   = 3'd2;
    localparam logic [2:0] st_hit_w       = 3'd3;
    localparam logic [2:0] st_miss_w      = 3'd4;
    localparam logic [2:0] st_miss_r_wait  = 3'd5;
    localparam logic [2:0] st_miss_r_wait1 = 3'd6;

    logic [2:0] state;
    logic [2:0] next_state;
    logic [2:0] accept_state;
    logic       miss;
    logic       rd_done;

    // uncached always counts as a miss, it has to reach memory
    assign miss = ~|hit | buf_uncached;

    // where to go when a new request may be taken
    assign accept_state = req_valid ? (req_op ? st_operation : st_lookup) : st_idle;

    // read data arrives, either straight in lookup or in the wait state
    assign rd_done = mem_data_ok &&
                     ((state == st_miss_r_wait) ||
                      (state == st_lookup && !buf_write && miss));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = st_idle;
        case (state)
            st_idle, st_operation, st_miss_r_wait1: begin
                next_state = accept_state;
            end
            st_lookup: begin
                if (buf_write) begin
                    // write through, done as soon as memory takes it
                    if (mem_addr_ok) begin
                        next_state = accept_state;
                    end else begin
                        next_state = miss ? st_miss_w : st_hit_w;
                    end
                end else if (miss) begin
                    next_state = mem_data_ok ? st_miss_r_wait1 : st_miss_r_wait;
                end else begin
                    next_state = accept_state;
                end
            end
            st_hit_w, st_miss_w: begin
                next_state = mem_addr_ok ? accept_state : state;
            end
            st_miss_r_wait: begin
                next_state = mem_data_ok ? st_miss_r_wait1 : st_miss_r_wait;
            end
            default: next_state = st_idle;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        req_ready  = 1'b0;
        resp_valid = 1'b0;
        op_ack     = 1'b0;
        mem_req    = 1'b0;
        mem_wr     = 1'b0;
        data_we    = '0;
        fill       = '0;
        inval      = '0;
        init       = '0;
        use0       = 1'b0;
        use1       = 1'b0;
        way_sel    = 1'b0;
        return_sel = 1'b0;
        case (state)
            st_idle: begin
                req_ready = 1'b1;
            end
            st_lookup: begin
                // strongly ordered access drops any copy it finds
                if (buf_uncached) begin
                    inval = hit;
                end
                mem_req = buf_write | miss;
                mem_wr  = buf_write;
                if (!miss) begin
                    use0    = hit[0];
                    use1    = hit[1];
                    way_sel = hit[1];
                    // store hit, keep the line in step with memory
                    if (buf_write) begin
                        data_we = hit;
                    end
                end
                if (buf_write) begin
                    req_ready = mem_addr_ok;
                end else if (!miss) begin
                    req_ready  = 1'b1;
                    resp_valid = 1'b1;
                end
            end
            st_operation: begin
                req_ready = 1'b1;
                op_ack    = 1'b1;
                case (buf_cacheop)
                    op_index_init:  init[buf_addr.op.way]  = 1'b1;
                    op_index_inval: inval[buf_addr.op.way] = 1'b1;
                    op_hit_inval:   inval = hit;
                    default: ;
                endcase
            end
            st_hit_w, st_miss_w: begin
                mem_req   = 1'b1;
                mem_wr    = 1'b1;
                req_ready = mem_addr_ok;
            end
            st_miss_r_wait: begin
                mem_req = 1'b1;
            end
            st_miss_r_wait1: begin
                req_ready = 1'b1;
            end
            default: ;
        endcase

        // return memory word, refill victim only for cached reads
        if (rd_done) begin
            resp_valid = 1'b1;
            return_sel = 1'b1;
            if (!buf_uncached) begin
                data_we[victim] = 1'b1;
                fill[victim]    = 1'b1;
                use0            = ~victim;
                use1            = victim;
            end
        end

        // buffer takes the request in the same cycle it is accepted
        buf_load = req_ready;
    end

    // a tag never lives in both ways of a set
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(hit));

endmodule

//--- verilog/dcache_top.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_top import dcache_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    // pipeline side
    input  logic         req_valid,
    input  logic         req_op,
    input  logic         req_write,
    input  logic         req_uncached,
    input  cacheop_e     req_cacheop,
    input  dcache_addr_u req_addr,
    input  logic [31:0]  req_wdata,
    input  logic [3:0]   req_wstrb,
    output logic         req_ready,
    output logic         resp_valid,
    output logic [31:0]  resp_rdata,
    output logic         op_ack,
    // memory side
    output logic         mem_req,
    output logic         mem_wr,
    output logic [31:0]  mem_addr,
    output logic [31:0]  mem_wdata,
    output logic [3:0]   mem_wstrb,
    input  logic         mem_addr_ok,
    input  logic         mem_data_ok,
    input  logic [31:0]  mem_rdata
);

    logic                    buf_load;
    logic                    buf_op;
    logic                    buf_write;
    logic                    buf_uncached;
    cacheop_e                buf_cacheop;
    dcache_addr_u            buf_addr;
    logic [31:0]             buf_wdata;
    logic [3:0]              buf_wstrb;
    logic [`DCACHE_WAYS-1:0] hit;
    logic [`DCACHE_WAYS-1:0] data_we;
    logic [`DCACHE_WAYS-1:0] fill;
    logic [`DCACHE_WAYS-1:0] inval;
    logic [`DCACHE_WAYS-1:0] init;
    logic [31:0]             way_rdata [`DCACHE_WAYS];
    logic                    use0;
    logic                    use1;
    logic                    victim;
    logic                    way_sel;
    logic                    return_sel;

    // memory always sees the buffered request
    assign mem_addr  = buf_addr;
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wstrb;

    // refill data bypasses the arrays, hit data comes from the hitting way
    assign resp_rdata = return_sel ? mem_rdata : way_rdata[way_sel];

    dcache_req_buf dcache_req_buf_i (
        .clk, .rstn, .load(buf_load),
        .req_op, .req_write, .req_uncached, .req_cacheop,
        .req_addr, .req_wdata, .req_wstrb,
        .buf_op, .buf_write, .buf_uncached, .buf_cacheop,
        .buf_addr, .buf_wdata, .buf_wstrb
    );

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        dcache_way dcache_way_i (
            .clk, .rstn, .addr(buf_addr),
            .wdata(buf_wdata), .fill_data(mem_rdata), .wstrb(buf_wstrb),
            .data_we(data_we[w]), .fill(fill[w]),
            .inval(inval[w]), .init(init[w]),
            .hit(hit[w]), .rdata(way_rdata[w])
        );
    end

    dcache_lru dcache_lru_i (
        .clk, .rstn, .index(buf_addr.cache.index),
        .use0, .use1, .victim
    );

    dcache_fsm dcache_fsm_i (
        .clk, .rstn,
        .req_valid, .req_op, .req_ready, .resp_valid, .op_ack,
        .buf_load, .buf_write, .buf_uncached, .buf_cacheop, .buf_addr,
        .hit, .victim, .data_we, .fill, .inval, .init, .use0, .use1,
        .mem_addr_ok, .mem_data_ok, .mem_req, .mem_wr,
        .way_sel, .return_sel
    );

    // op_ack only ever answers a buffered cache op
    a_ack_is_op: assert property (@(posedge clk) disable iff (!rstn)
        op_ack |-> buf_op);

    // loads only, stores never produce a response
    a_resp_is_read: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid |-> !buf_write && !buf_op);

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rstn
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held low for the first 3 rising edges
    initial begin
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

//--- tests/dcache_tb.sv
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_tb import dcache_pkg::*;;

    localparam int num_reqs       = 320;
    localparam int cycles_per_req = 20;
    localparam int mem_words      = 64;
    localparam int sets           = 1 << `DCACHE_INDEX_W;

    logic         clk;
    logic         rstn;
    logic         req_valid;
    logic         req_op;
    logic         req_write;
    logic         req_uncached;
    cacheop_e     req_cacheop;
    dcache_addr_u req_addr;
    logic [31:0]  req_wdata;
    logic [3:0]   req_wstrb;
    logic         req_ready;
    logic         resp_valid;
    logic [31:0]  resp_rdata;
    logic         op_ack;
    logic         mem_req;
    logic         mem_wr;
    logic [31:0]  mem_addr;
    logic [31:0]  mem_wdata;
    logic [3:0]   mem_wstrb;
    logic         mem_addr_ok;
    logic         mem_data_ok;
    logic [31:0]  mem_rdata;

    // expected read words, oldest first
    logic [31:0]  exp_q[$];
    logic [31:0]  ref_mem [mem_words];
    logic [31:0]  mem_store [mem_words];

    // request currently owned by the DUT
    dcache_addr_u cur_addr;
    logic         cur_write;
    logic [31:0]  cur_wdata;
    logic [3:0]   cur_wstrb;

    int           errors;
    int           n_reqs;
    int           n_mem_reads;
    int           n_mem_writes;
    int           tests_run;
    int           tests_bad;
    int           test_err0;
    string        test_name;
    int           r0;
    int           w0;
    logic [31:0]  stim_rng;
    logic [31:0]  mem_rng;
    logic [31:0]  rnd_word;
    logic         ok_pending;
    logic [1:0]   delay;

    tb_clock tb_clock_i (.clk, .rstn);

    dcache_top dcache_top_i (.*);

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // every bit of the byte address feeds the pattern
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b9) ^ 32'hc3a5_5a3c;
    endfunction

    // write-through keeps cache and memory equal, so memory is the answer
    function automatic logic [31:0] ref_read(input dcache_addr_u a);
        return ref_mem[a[7:2]];
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wdata,
                                                input logic [3:0] wstrb);
        logic [31:0] w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                w[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return w;
    endfunction

    function automatic dcache_addr_u word_addr(input int w);
        dcache_addr_u a;
        a = 32'(w) << 2;
        return a;
    endfunction

    // index op view, way in bit 0
    function automatic dcache_addr_u op_addr(input int set, input logic way);
        dcache_addr_u a;
        a = '0;
        a.op.index = set[`DCACHE_INDEX_W-1:0];
        a.op.way = way;
        return a;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic check_data(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input dcache_addr_u got,
                              input dcache_addr_u exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic expect_mem(input string what, input int dr, input int dw);
        if (n_mem_reads - r0 != dr || n_mem_writes - w0 != dw) begin
            errors++;
            $display("%s: memory saw %0d reads and %0d writes, wanted %0d and %0d",
                     what, n_mem_reads - r0, n_mem_writes - w0, dr, dw);
        end
        r0 = n_mem_reads;
        w0 = n_mem_writes;
    endtask

    // every response is checked against the oldest expected word
    always @(negedge clk) begin
        if (rstn && resp_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("response seen with no read outstanding");
            end else begin
                check_data("resp_rdata", resp_rdata, exp_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////////////////////////

    initial begin
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata = '0;
        mem_rng = xorshift(32'hb3a444e9);
        for (int i = 0; i < mem_words; i++) begin
            mem_store[i] = fill_word(32'(i) << 2);
        end
    end

    always @(posedge clk) begin
        mem_addr_ok <= 1'b0;
        mem_data_ok <= 1'b0;
        if (!rstn) begin
            ok_pending <= 1'b0;
            delay <= '0;
        end else if (ok_pending) begin
            // handshake finished on this edge
            ok_pending <= 1'b0;
        end else if (mem_req === 1'b1) begin
            if (delay != 0) begin
                delay <= delay - 1'b1;
            end else begin
                check_addr("mem_addr", mem_addr, cur_addr);
                if (mem_wr !== cur_write) begin
                    errors++;
                    $display("memory request has the wrong direction");
                end
                if (mem_wr) begin
                    check_data("mem_wdata", mem_wdata, cur_wdata);
                    check_data("mem_wstrb", {28'b0, mem_wstrb}, {28'b0, cur_wstrb});
                    mem_store[mem_addr[7:2]] = merge_bytes(mem_store[mem_addr[7:2]],
                                                           mem_wdata, mem_wstrb);
                    mem_addr_ok <= 1'b1;
                    n_mem_writes++;
                end else begin
                    mem_rdata <= mem_store[mem_addr[7:2]];
                    mem_data_ok <= 1'b1;
                    n_mem_reads++;
                end
                ok_pending <= 1'b1;
                mem_rng = xorshift(mem_rng);
                delay <= mem_rng[1:0];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // request tasks
    //////////////////////////////////////////////////////////////////////

    // returns on the edge that transfers the request
    task automatic issue(input logic op, input logic write, input logic uncached,
                         input cacheop_e cop, input dcache_addr_u a,
                         input logic [31:0] wdata, input logic [3:0] wstrb);
        @(posedge clk);
        req_valid <= 1'b1;
        req_op <= op;
        req_write <= write;
        req_uncached <= uncached;
        req_cacheop <= cop;
        req_addr <= a;
        req_wdata <= wdata;
        req_wstrb <= wstrb;
        cur_addr = a;
        cur_write = write;
        cur_wdata = wdata;
        cur_wstrb = wstrb;
        n_reqs++;
        if (!op && !write) begin
            exp_q.push_back(ref_read(a));
        end else if (!op) begin
            ref_mem[a[7:2]] = merge_bytes(ref_mem[a[7:2]], wdata, wstrb);
        end
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!req_ready) @(negedge clk);
    endtask

    task automatic read_word(input int w, input logic uncached);
        issue(1'b0, 1'b0, uncached, op_index_init, word_addr(w), '0, '0);
        wait_done();
    endtask

    task automatic write_word(input int w, input logic [31:0] d, input logic [3:0] strb,
                              input logic uncached);
        issue(1'b0, 1'b1, uncached, op_index_init, word_addr(w), d, strb);
        wait_done();
    endtask

    // op_ack is due in the first cycle after acceptance
    task automatic cache_op(input cacheop_e cop, input dcache_addr_u a);
        issue(1'b1, 1'b0, 1'b0, cop, a, '0, '0);
        @(negedge clk);
        if (op_ack !== 1'b1) begin
            errors++;
            $display("%s was not acknowledged one cycle after acceptance", cop.name());
        end
        while (!req_ready) @(negedge clk);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors;
        r0 = n_mem_reads;
        w0 = n_mem_writes;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err0) begin
            $display("test %0d %s: ok", tests_run, test_name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests_run, test_name, errors - test_err0);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        req_valid = 1'b0;
        req_op = 1'b0;
        req_write = 1'b0;
        req_uncached = 1'b0;
        req_cacheop = op_index_init;
        req_addr = '0;
        req_wdata = '0;
        req_wstrb = '0;
        stim_rng = 32'hb3a444e9;
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i] = fill_word(32'(i) << 2);
        end
        wait (rstn === 1'b1);

        start_test("read miss then hit");
        read_word(5, 1'b0);
        expect_mem("first read of word 5", 1, 0);
        read_word(5, 1'b0);
        expect_mem("second read of word 5", 0, 0);
        end_test();

        start_test("strobed write hit");
        stim_rng = xorshift(stim_rng);
        write_word(5, stim_rng, 4'b0101, 1'b0);
        expect_mem("write hit of word 5", 0, 1);
        read_word(5, 1'b0);
        expect_mem("read after write hit", 0, 0);
        end_test();

        start_test("write miss no allocate");
        write_word(9, 32'h1234_5678, 4'b1111, 1'b0);
        expect_mem("write miss of word 9", 0, 1);
        read_word(9, 1'b0);
        expect_mem("read after write miss", 1, 0);
        end_test();

        // uncached traffic drops any cached copy
        start_test("uncached access");
        read_word(5, 1'b1);
        expect_mem("uncached read of word 5", 1, 0);
        read_word(5, 1'b0);
        expect_mem("cached read after uncached read", 1, 0);
        write_word(5, 32'hcafe_f00d, 4'b1100, 1'b1);
        expect_mem("uncached write of word 5", 0, 1);
        read_word(5, 1'b0);
        expect_mem("cached read after uncached write", 1, 0);
        read_word(9, 1'b1);
        expect_mem("uncached read of cached word 9", 1, 0);
        end_test();

        start_test("cache ops");
        read_word(12, 1'b0);
        expect_mem("fill of word 12", 1, 0);
        cache_op(op_index_inval, op_addr(12 % sets, 1'b0));
        cache_op(op_index_inval, op_addr(12 % sets, 1'b1));
        read_word(12, 1'b0);
        expect_mem("read after index invalidate", 1, 0);
        cache_op(op_index_init, op_addr(12 % sets, 1'b0));
        cache_op(op_index_init, op_addr(12 % sets, 1'b1));
        read_word(12, 1'b0);
        expect_mem("read after index init", 1, 0);
        cache_op(op_hit_inval, word_addr(12));
        read_word(12, 1'b0);
        expect_mem("read after hit invalidate", 1, 0);
        end_test();

        // 64 words over 16 sets, four tags compete per set
        start_test("random mix");
        for (int i = 0; i < 300; i++) begin
            stim_rng = xorshift(stim_rng);
            rnd_word = stim_rng;
            stim_rng = xorshift(stim_rng);
            case (rnd_word[2:0])
                3'd4, 3'd5: write_word(rnd_word[13:8], stim_rng, rnd_word[19:16], 1'b0);
                3'd6:       read_word(rnd_word[13:8], 1'b1);
                3'd7:       write_word(rnd_word[13:8], stim_rng, rnd_word[19:16], 1'b1);
                default:    read_word(rnd_word[13:8], 1'b0);
            endcase
        end
        end_test();

        repeat (2) @(posedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d reads never got a response", exp_q.size());
        end
        $display("%0d tests, %0d failing, %0d requests, %0d errors",
                 tests_run, tests_bad, n_reqs, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (num_reqs * cycles_per_req) @(posedge clk);
        $display("run stopped after %0d cycles, the DUT stopped answering requests",
                 num_reqs * cycles_per_req);
        $display("Test failed");
        $finish;
    end

endmodule

//--- project.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_req_buf.sv
verilog/dcache_lru.sv
verilog/dcache_way.sv
verilog/dcache_fsm.sv
verilog/dcache_top.sv
tests/tb_clock.sv
tests/dcache_tb.sv
